// ==== src/ql_bus_pkg.sv ====
// ql bus package: widths, region and slot enums, request and response structs for the shared bus
`default_nettype none

package ql_bus_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------

	localparam int cpu_addr_w = 20;     // 68008 byte address, 1 MB
	localparam int mem_addr_w = 25;     // external memory word address

	typedef logic [15:0] word_t;        // one bus word

	// processor address regions
	typedef enum logic [2:0] {
		rom,                            // 64k at 0x00000
		base_ram,                       // 128k at 0x20000
		ext_ram,                        // 512k at 0x40000, optional
		io,                             // internal io at 0x18000
		none                            // nothing mapped
	} region_e;

	// who owns the current bus slot
	typedef enum logic {
		video_slot,                     // display and microdrive
		sys_slot                        // processor and download
	} slot_e;

	// ----------------------------------------------------------------------
	// request structs
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic [cpu_addr_w-1:0] addr;    // byte address
		logic                  rd;
		logic                  wr;
		logic                  uds;     // upper byte lane, active high
		logic                  lds;     // lower byte lane
		word_t                 wdata;
	} cpu_req_t;

	typedef struct packed {
		logic                  active;  // download in progress
		logic [4:0]            index;   // 0 and 3 are rom images
		logic [mem_addr_w-1:0] addr;    // already a word address
		word_t                 data;
		logic                  write;   // word ready
	} dl_req_t;

	typedef struct packed {
		logic        rd;
		logic [18:0] addr;              // word address into screen memory
	} disp_req_t;

	typedef struct packed {
		logic                  read1;   // mdv1 wants a word
		logic                  read2;   // mdv2 wants a word
		logic                  seldrive;
		logic [mem_addr_w-1:0] addr1;
		logic [mem_addr_w-1:0] addr2;
	} mdv_req_t;

	// one transfer as seen by the memory controller
	typedef struct packed {
		logic [mem_addr_w-1:0] addr;
		logic                  we;
		logic                  oe;
		logic                  uds;
		logic                  lds;
		word_t                 wdata;
	} mem_req_t;

	typedef struct packed {
		mem_req_t req;
		logic     need;                 // slot wants the memory
		logic     skip;                 // slot has work but no memory transfer
	} slot_req_t;

	// word handed back to display or microdrive
	typedef struct packed {
		logic  valid;
		logic  to_mdv;
		logic  drive;                   // 1 = mdv2
		word_t data;
	} fetch_t;

endpackage

`default_nettype wire

// ==== src/cpu_reset_gen.sv ====
// cpu reset gen: stretched processor reset after system reset, button or rom download
`default_nettype none
`timescale 1ns/1ps

module cpu_reset_gen #(
	parameter int reset_len = 4095              // stretch in clk2 cycles
) (
	input  logic                clk2,
	input  logic                rst,
	input  logic                reset_button,
	input  ql_bus_pkg::dl_req_t dl_req,
	output logic                cpu_reset
);

	localparam int cnt_w = $clog2(reset_len + 1);

	logic [cnt_w-1:0] cnt;
	logic             rom_dl;

	// a rom image overwrites code the cpu would run
	assign rom_dl = dl_req.active && (dl_req.index == 5'd0 || dl_req.index == 5'd3);

	always_ff @(posedge clk2) begin
		if (rst || reset_button || rom_dl)
			cnt <= cnt_w'(reset_len);                // reload, counts from the last cause
		else if (cnt != '0)
			cnt <= cnt - cnt_w'(1);
	end

	assign cpu_reset = (cnt != '0);

endmodule

`default_nettype wire

// ==== src/sys_port.sv ====
// sys port: processor and download muxing onto the system slot, address decode and read return
`default_nettype none
`timescale 1ns/1ps

module sys_port (
	input  logic                 clk2,
	input  logic                 rst,
	input  ql_bus_pkg::cpu_req_t cpu_req,
	input  logic                 ram_640k,
	input  ql_bus_pkg::dl_req_t  dl_req,
	input  logic                 slot_done,
	input  logic                 is_sys,
	input  ql_bus_pkg::word_t    rd_word,
	output ql_bus_pkg::slot_req_t sys_slot,
	output logic                 cpu_done,
	output ql_bus_pkg::word_t    cpu_rdata
);
	import ql_bus_pkg::*;

	region_e region;
	logic    cpu_act;     // live access, muted in the done cycle
	logic    cpu_ram;
	logic    cpu_mem_rd;  // read served from memory
	logic    cpu_need;
	logic    dl_mode;     // stays set until the last download slot is done
	logic    dl_sel;
	logic    sys_end;

	// ----------------------------------------------------------------------
	// address decode
	// ----------------------------------------------------------------------

	always_comb begin
		if (cpu_req.addr[19:16] == 4'h0)
			region = rom;                                   // 00000-0ffff
		else if (cpu_req.addr[19:14] == 6'b000110)
			region = io;                                    // 18000-1bfff
		else if (cpu_req.addr[19:17] == 3'b001)
			region = base_ram;                              // 20000-3ffff
		else if (ram_640k && (cpu_req.addr[19:18] == 2'b01 ||
		                      cpu_req.addr[19:18] == 2'b10))
			region = ext_ram;                               // 40000-bffff
		else
			region = none;
	end

	assign cpu_act    = (cpu_req.rd || cpu_req.wr) && !cpu_done;
	assign cpu_ram    = (region == base_ram) || (region == ext_ram);
	assign cpu_mem_rd = cpu_req.rd && (cpu_ram || region == rom);
	assign cpu_need   = cpu_mem_rd || (cpu_req.wr && cpu_ram); // rom is read only
	assign dl_sel     = dl_req.active || dl_mode;
	assign sys_end    = slot_done && is_sys;

	// ----------------------------------------------------------------------
	// slot request
	// ----------------------------------------------------------------------

	always_comb begin
		sys_slot = '0;
		if (dl_sel) begin
			// download owns the slot, processor waits
			sys_slot.req.addr  = dl_req.addr;
			sys_slot.req.we    = 1'b1;
			sys_slot.req.uds   = 1'b1;
			sys_slot.req.lds   = 1'b1;
			sys_slot.req.wdata = dl_req.data;
			sys_slot.need      = dl_req.active && dl_req.write;
			sys_slot.skip      = !dl_req.active;          // one empty pass closes dl mode
		end else begin
			sys_slot.req.addr  = mem_addr_w'(cpu_req.addr[cpu_addr_w-1:1]); // byte to word
			sys_slot.req.we    = cpu_req.wr && cpu_ram;
			sys_slot.req.oe    = cpu_mem_rd;
			sys_slot.req.uds   = cpu_req.uds;
			sys_slot.req.lds   = cpu_req.lds;
			sys_slot.req.wdata = cpu_req.wdata;
			sys_slot.need      = cpu_act && cpu_need;
			sys_slot.skip      = cpu_act && !cpu_need;    // io, unmapped, rom write
		end
	end

	// download mode tail, covers a download slot still in flight
	always_ff @(posedge clk2) begin
		if (rst)
			dl_mode <= 1'b0;
		else if (dl_req.active)
			dl_mode <= 1'b1;
		else if (sys_end)
			dl_mode <= 1'b0;
	end

	// ----------------------------------------------------------------------
	// completion back to the processor
	// ----------------------------------------------------------------------

	always_ff @(posedge clk2) begin
		if (rst)
			cpu_done <= 1'b0;
		else
			cpu_done <= sys_end && !dl_sel;               // single cycle strobe
	end

	always_ff @(posedge clk2) begin
		if (sys_end && !dl_sel)
			cpu_rdata <= cpu_mem_rd ? rd_word : 16'hffff; // open bus reads as ones
	end

endmodule

`default_nettype wire

// ==== src/video_port.sv ====
// video port: display and microdrive address select for the video slot, fetched word latch
`default_nettype none
`timescale 1ns/1ps

module video_port (
	input  logic                  clk2,
	input  logic                  rst,
	input  ql_bus_pkg::disp_req_t disp_req,
	input  ql_bus_pkg::mdv_req_t  mdv_req,
	input  logic                  slot_done,
	input  logic                  is_video,
	input  ql_bus_pkg::word_t     rd_word,
	output ql_bus_pkg::slot_req_t video_slot,
	output ql_bus_pkg::fetch_t    fetch_out
);
	import ql_bus_pkg::*;

	logic  mdv_any;
	logic  want;
	logic  lock;                  // source choice frozen for the slot in flight
	logic  lk_mdv, lk_drive;
	logic  use_mdv, use_drive;
	logic  video_end;
	logic  fetch_valid, fetch_mdv, fetch_drive;
	word_t fetch_data;

	assign mdv_any   = mdv_req.read1 || mdv_req.read2;
	assign want      = (mdv_any || disp_req.rd) && !fetch_valid;  // quiet while handing over
	assign use_mdv   = lock ? lk_mdv : mdv_any;                   // microdrive beats display
	assign use_drive = lock ? lk_drive : mdv_req.seldrive;
	assign video_end = slot_done && is_video;

	// read only slot, both lanes
	always_comb begin
		video_slot = '0;
		if (use_mdv)
			video_slot.req.addr = use_drive ? mdv_req.addr2 : mdv_req.addr1;
		else
			video_slot.req.addr = mem_addr_w'(disp_req.addr);
		video_slot.req.oe  = 1'b1;
		video_slot.req.uds = 1'b1;
		video_slot.req.lds = 1'b1;
		video_slot.need    = want;
	end

	always_ff @(posedge clk2) begin
		if (rst)
			lock <= 1'b0;
		else if (video_end)
			lock <= 1'b0;
		else if (want)
			lock <= 1'b1;
	end

	always_ff @(posedge clk2) begin
		if (!lock) begin
			lk_mdv   <= mdv_any;
			lk_drive <= mdv_req.seldrive;
		end
	end

	// ----------------------------------------------------------------------
	// fetch register, held while the system slot runs
	// ----------------------------------------------------------------------

	always_ff @(posedge clk2) begin
		if (rst)
			fetch_valid <= 1'b0;
		else
			fetch_valid <= video_end;
	end

	always_ff @(posedge clk2) begin
		if (video_end) begin
			fetch_mdv   <= use_mdv;
			fetch_drive <= use_mdv && use_drive;          // 0 for display words
			fetch_data  <= rd_word;
		end
	end

	always_comb begin
		fetch_out.valid  = fetch_valid;
		fetch_out.to_mdv = fetch_mdv;
		fetch_out.drive  = fetch_drive;
		fetch_out.data   = fetch_data;
	end

endmodule

`default_nettype wire

// ==== src/slot_sequencer.sv ====
// slot sequencer: alternates video and system slots and runs the four-phase memory handshake
`default_nettype none
`timescale 1ns/1ps

module slot_sequencer (
	input  logic                  clk2,
	input  logic                  rst,
	input  ql_bus_pkg::slot_req_t sys_slot,
	input  ql_bus_pkg::slot_req_t video_slot,
	output ql_bus_pkg::mem_req_t  mem_req,
	output logic                  mem_req_valid,
	input  logic                  mem_ack,
	input  ql_bus_pkg::word_t     mem_rdata,
	output logic                  slot_done,
	output ql_bus_pkg::slot_e     owner,
	output ql_bus_pkg::word_t     rd_word
);
	import ql_bus_pkg::*;

	typedef enum logic [1:0] {
		pick,          // start the slot of owner
		wait_ack_hi,   // req high, waiting for ack
		wait_ack_lo,   // req low, waiting for ack to drop
		finish         // done for owner, next slot starts here too
	} seq_state_e;

	seq_state_e state;
	slot_e      start_own;   // slot that starts this cycle
	slot_e      after_own;   // the one after it
	slot_req_t  start_req;
	logic       slot_start;

	// the port enum literals are hidden by the port names, so scope them
	always_comb begin
		start_own = (state == finish) ? slot_e'(~owner) : owner;
		after_own = slot_e'(~start_own);
		start_req = (start_own == ql_bus_pkg::sys_slot) ? sys_slot : video_slot;
	end

	assign slot_start = (state == pick) || (state == finish);
	assign slot_done  = (state == finish);   // owner still names the finishing slot

	// ----------------------------------------------------------------------
	// sequencer FSM
	// ----------------------------------------------------------------------

	always_ff @(posedge clk2) begin
		if (rst) begin
			state         <= pick;
			owner         <= ql_bus_pkg::video_slot;
			mem_req_valid <= 1'b0;
		end else begin
			case (state)
				pick, finish: begin
					if (start_req.need) begin
						owner         <= start_own;
						mem_req_valid <= 1'b1;          // req up one cycle after start
						state         <= wait_ack_hi;
					end else if (start_req.skip) begin
						owner <= start_own;
						state <= finish;                // done next cycle, no memory
					end else begin
						owner <= after_own;             // empty slot, one cycle
						state <= pick;
					end
				end
				wait_ack_hi: begin
					if (mem_ack) begin
						mem_req_valid <= 1'b0;          // phase 3
						state         <= wait_ack_lo;
					end
				end
				wait_ack_lo: begin
					if (!mem_ack)
						state <= finish;                // req may rise again from here
				end
				default: begin
					state <= pick;
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// request and data registers
	// ----------------------------------------------------------------------

	// request held stable from req rise until ack falls
	always_ff @(posedge clk2) begin
		if (slot_start && start_req.need)
			mem_req <= start_req.req;
	end

	// read data valid while ack is high, take it on the rise
	always_ff @(posedge clk2) begin
		if (state == wait_ack_hi && mem_ack)
			rd_word <= mem_rdata;
	end

endmodule

`default_nettype wire

// ==== src/ql_bus_arbiter.sv ====
// ql bus arbiter: shared memory bus top, system and video ports, slot sequencer and cpu reset
`default_nettype none
`timescale 1ns/1ps

module ql_bus_arbiter #(
	parameter int reset_len = 4095
) (
	input  logic                  clk2,
	input  logic                  rst,
	input  logic                  reset_button,
	input  ql_bus_pkg::cpu_req_t  cpu_req,
	input  logic                  ram_640k,
	input  ql_bus_pkg::dl_req_t   dl_req,
	input  ql_bus_pkg::disp_req_t disp_req,
	input  ql_bus_pkg::mdv_req_t  mdv_req,
	output logic                  cpu_done,
	output ql_bus_pkg::word_t     cpu_rdata,
	output ql_bus_pkg::fetch_t    fetch_out,
	output logic                  cpu_reset,
	output ql_bus_pkg::mem_req_t  mem_req,
	output logic                  mem_req_valid,
	input  logic                  mem_ack,
	input  ql_bus_pkg::word_t     mem_rdata
);
	import ql_bus_pkg::*;

	slot_req_t sys_sreq;     // processor or download side
	slot_req_t video_sreq;   // display or microdrive side
	slot_e     owner;
	word_t     rd_word;
	logic      slot_done;
	logic      is_sys, is_video;

	assign is_sys   = (owner == sys_slot);
	assign is_video = (owner == video_slot);

	// ----------------------------------------------------------------------
	// slot sources
	// ----------------------------------------------------------------------

	sys_port u_sys_port (
		.clk2      (clk2),
		.rst       (rst),
		.cpu_req   (cpu_req),
		.ram_640k  (ram_640k),
		.dl_req    (dl_req),
		.slot_done (slot_done),
		.is_sys    (is_sys),
		.rd_word   (rd_word),
		.sys_slot  (sys_sreq),
		.cpu_done  (cpu_done),
		.cpu_rdata (cpu_rdata)
	);

	video_port u_video_port (
		.clk2       (clk2),
		.rst        (rst),
		.disp_req   (disp_req),
		.mdv_req    (mdv_req),
		.slot_done  (slot_done),
		.is_video   (is_video),
		.rd_word    (rd_word),
		.video_slot (video_sreq),
		.fetch_out  (fetch_out)
	);

	// ----------------------------------------------------------------------
	// memory side and reset
	// ----------------------------------------------------------------------

	slot_sequencer u_slot_sequencer (
		.clk2          (clk2),
		.rst           (rst),
		.sys_slot      (sys_sreq),
		.video_slot    (video_sreq),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_ack       (mem_ack),
		.mem_rdata     (mem_rdata),
		.slot_done     (slot_done),
		.owner         (owner),
		.rd_word       (rd_word)
	);

	cpu_reset_gen #(
		.reset_len (reset_len)
	) u_cpu_reset_gen (
		.clk2         (clk2),
		.rst          (rst),
		.reset_button (reset_button),
		.dl_req       (dl_req),
		.cpu_reset    (cpu_reset)
	);

endmodule

`default_nettype wire

// ==== verification/tb_ql_bus_ref.svh ====
// ql bus reference model with expected region, addresses and data, lfsr and value compare
`ifndef TB_QL_BUS_REF_SVH
`define TB_QL_BUS_REF_SVH

// ----------------------------------------------------------------------
// memory contents as the model holds them
// ----------------------------------------------------------------------

// untouched words follow the whole address
function automatic word_t fill_word(input logic [24:0] wa);
	return wa[15:0] ^ {wa[24:16], 7'h5a};
endfunction

function automatic word_t mem_peek(input logic [24:0] wa);
	return mem.exists(wa) ? mem[wa] : fill_word(wa);
endfunction

// ----------------------------------------------------------------------
// expected behaviour of the bus
// ----------------------------------------------------------------------

function automatic region_e region_of(input logic [19:0] a, input logic big);
	if (a < 20'h10000)
		return rom;
	if (a >= 20'h18000 && a < 20'h1c000)
		return io;
	if (a >= 20'h20000 && a < 20'h40000)
		return base_ram;
	if (big && a >= 20'h40000 && a < 20'hc0000)
		return ext_ram;                                // only with the 640k option
	return none;
endfunction

function automatic logic [24:0] word_addr_of(input logic [19:0] a);
	return 25'(a >> 1);                                // byte to word
endfunction

function automatic word_t expected_read(input logic [19:0] a, input logic big);
	region_e r;
	r = region_of(a, big);
	if (r == rom || r == base_ram || r == ext_ram)
		return mem_peek(word_addr_of(a));
	return 16'hffff;                                   // io and open space
endfunction

// memory word after a processor write
function automatic word_t written_word(input word_t old, input word_t wd,
                                       input logic uds, input logic lds, input region_e r);
	word_t res;
	res = old;
	if (r != base_ram && r != ext_ram)
		return old;                                    // rom, io and none ignore writes
	if (uds)
		res[15:8] = wd[15:8];
	if (lds)
		res[7:0] = wd[7:0];
	return res;
endfunction

// microdrive beats display and seldrive picks drive 2
function automatic logic [24:0] fetch_addr_of(input logic m1, input logic m2, input logic sel,
                                             input logic [18:0] da, input logic [24:0] a1,
                                             input logic [24:0] a2);
	if (m1 || m2)
		return sel ? a2 : a1;
	return 25'(da);
endfunction

// ----------------------------------------------------------------------
// lfsr and compare
// ----------------------------------------------------------------------

function automatic logic lfsr_step();
	logic fb;
	fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];   // x^16+x^14+x^13+x^11+1
	lfsr_q = {lfsr_q[14:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
		r = {r[30:0], lfsr_step()};                    // one step per bit
	return r;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		errors++;
	end
endtask

`endif

// ==== verification/tb_ql_bus.sv ====
// ql bus testbench with a memory model, directed and random bus traffic and reset stretch checks
`timescale 1ns/1ps
`default_nettype none

module tb_ql_bus;
	import ql_bus_pkg::*;

	localparam int stretch = 20;
	localparam int wd_ns = 40000;   // six tests of a few hundred cycles each with slow acks

	typedef struct packed {
		logic  chk;                 // reads only
		word_t data;
	} cpu_exp_t;

	logic clk2, rst, reset_button, ram_640k, mem_ack;
	cpu_req_t  cpu_req;
	dl_req_t   dl_req;
	disp_req_t disp_req;
	mdv_req_t  mdv_req;
	logic      cpu_done, cpu_reset, mem_req_valid;
	word_t     cpu_rdata, mem_rdata;
	fetch_t    fetch_out;
	mem_req_t  mem_req;

	word_t       mem [logic [24:0]];     // sparse memory
	logic [15:0] lfsr_q = 16'd11028;
	int          xfers, wr_count, errors, checks, tests_run, tests_failed, errs_at_start;
	cpu_exp_t    cpu_q[$];
	fetch_t      fetch_q[$];
	time         dl_end_t, cpu_end_t;

	`include "tb_ql_bus_ref.svh"

	ql_bus_arbiter #(.reset_len(stretch)) dut0 (
		.clk2(clk2), .rst(rst), .reset_button(reset_button), .cpu_req(cpu_req),
		.ram_640k(ram_640k), .dl_req(dl_req), .disp_req(disp_req), .mdv_req(mdv_req),
		.cpu_done(cpu_done), .cpu_rdata(cpu_rdata), .fetch_out(fetch_out),
		.cpu_reset(cpu_reset), .mem_req(mem_req), .mem_req_valid(mem_req_valid),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	always #4 clk2 = ~clk2;

	// ----------------------------------------------------------------------
	// memory model as a four-phase slave with 0 to 3 cycles of ack delay
	// ----------------------------------------------------------------------

	initial begin : mem_model
		int          d;
		logic [24:0] a;
		word_t       w;
		mem_ack = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk2);
			#1;
			if (mem_req_valid && !mem_ack) begin
				d = int'(rand_bits(2));
				repeat (d) begin
					@(posedge clk2);
					#1;
				end
				a = mem_req.addr;
				w = mem_peek(a);
				check("mem_req.oe", 32'(mem_req.oe), 32'(!mem_req.we));  // read or write
				if (mem_req.we) begin
					if (mem_req.uds) w[15:8] = mem_req.wdata[15:8];
					if (mem_req.lds) w[7:0] = mem_req.wdata[7:0];
					mem[a] = w;
					wr_count++;
				end
				mem_rdata = w;
				mem_ack = 1'b1;
				xfers++;
				do begin
					@(posedge clk2);
					#1;
				end while (mem_req_valid);          // wait for req to drop
				mem_ack = 1'b0;
			end
		end
	end

	// compares every completion with the queued expectation
	always @(negedge clk2) begin : result_check
		cpu_exp_t e;
		fetch_t   f;
		if (!rst && cpu_done) begin
			if (cpu_q.size() == 0) begin
				$display("cpu_done at %0t with no processor access outstanding", $time);
				errors++;
			end else begin
				e = cpu_q.pop_front();
				if (e.chk) check("cpu_rdata", 32'(cpu_rdata), 32'(e.data));
			end
		end
		if (!rst && fetch_out.valid) begin
			if (fetch_q.size() == 0) begin
				$display("fetch_out.valid at %0t with no fetch outstanding", $time);
				errors++;
			end else begin
				f = fetch_q.pop_front();
				check("fetch_out.data", 32'(fetch_out.data), 32'(f.data));
				check("fetch_out.to_mdv", 32'(fetch_out.to_mdv), 32'(f.to_mdv));
				check("fetch_out.drive", 32'(fetch_out.drive), 32'(f.drive));
			end
		end
	end

	initial begin : watchdog
		#(wd_ns);
		$display("watchdog: simulation ran past its time limit");
		$display("TEST FAIL");
		$finish;
	end

	// ----------------------------------------------------------------------
	// stimulus tasks
	// ----------------------------------------------------------------------

	task automatic cpu_access(input logic [19:0] a, input logic rd, input logic wr,
	                          input logic uds, input logic lds, input word_t wd);
		cpu_exp_t    e;
		word_t       old;
		logic [24:0] wa;
		int          n;
		wa = word_addr_of(a);
		old = mem_peek(wa);
		e.chk = rd;
		e.data = expected_read(a, ram_640k);
		cpu_q.push_back(e);
		@(posedge clk2);
		#1;
		cpu_req.addr = a;
		cpu_req.rd = rd;
		cpu_req.wr = wr;
		cpu_req.uds = uds;
		cpu_req.lds = lds;
		cpu_req.wdata = wd;
		n = 0;
		do begin
			@(posedge clk2);
			#1;
			n++;
		end while (!cpu_done && n < 300);
		cpu_req.rd = 1'b0;                              // request drops in the done cycle
		cpu_req.wr = 1'b0;
		if (!cpu_done) begin
			$display("processor access to %h never completed", a);
			errors++;
			e = cpu_q.pop_back();
		end
		if (wr)
			check("memory word", 32'(mem_peek(wa)),
			      32'(written_word(old, wd, uds, lds, region_of(a, ram_640k))));
		cpu_end_t = $time;
	endtask

	task automatic measure_stretch(input string name);
		int n;
		n = 0;
		while (cpu_reset && n < 100) begin
			@(posedge clk2);
			#1;
			n++;
		end
		check(name, n, stretch);                        // cycles until cpu_reset falls
	endtask

	task automatic download_words(input int n, input logic [24:0] base, input logic [4:0] idx);
		word_t vals[8];
		int    w, k;
		@(posedge clk2);
		#1;
		dl_req.active = 1'b1;
		dl_req.index = idx;
		for (int i = 0; i < n; i++) begin
			vals[i] = word_t'(rand_bits(16));
			dl_req.addr = base + 25'(i);
			dl_req.data = vals[i];
			dl_req.write = 1'b1;
			w = wr_count;
			k = 0;
			while (wr_count == w && k < 100) begin
				@(posedge clk2);
				#1;
				k++;
			end
			if (wr_count == w) begin
				$display("download word %0d was never written", i);
				errors++;
			end
		end
		dl_req.write = 1'b0;
		dl_req.active = 1'b0;
		dl_end_t = $time;
		for (int i = 0; i < n; i++)
			check("download word", 32'(mem_peek(base + 25'(i))), 32'(vals[i]));
	endtask

	task automatic video_fetch(input logic dsp, input logic m1, input logic m2, input logic sel,
	                           input logic [18:0] da, input logic [24:0] a1, input logic [24:0] a2);
		fetch_t f;
		int     k;
		f.valid = 1'b1;
		f.to_mdv = m1 || m2;
		f.drive = (m1 || m2) && sel;
		f.data = mem_peek(fetch_addr_of(m1, m2, sel, da, a1, a2));
		fetch_q.push_back(f);
		@(posedge clk2);
		#1;
		disp_req.rd = dsp;
		disp_req.addr = da;
		mdv_req.read1 = m1;
		mdv_req.read2 = m2;
		mdv_req.seldrive = sel;
		mdv_req.addr1 = a1;
		mdv_req.addr2 = a2;
		k = 0;
		do begin
			@(posedge clk2);
			#1;
			k++;
		end while (!fetch_out.valid && k < 300);
		if (!fetch_out.valid) begin
			$display("video fetch never returned a word");
			errors++;
		end
		disp_req.rd = 1'b0;
		mdv_req.read1 = 1'b0;
		mdv_req.read2 = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errs_at_start) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		errs_at_start = errors;
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial begin : main
		logic [19:0] a;
		int          x0, w0;
		clk2 = 1'b0;
		rst = 1'b1;
		reset_button = 1'b0;
		ram_640k = 1'b0;
		cpu_req = '0;
		dl_req = '0;
		disp_req = '0;
		mdv_req = '0;
		repeat (4) @(posedge clk2);
		#1;
		rst = 1'b0;

		// test 1 covers the reset stretch
		check("cpu_reset", 32'(cpu_reset), 1);
		check("mem_req_valid", 32'(mem_req_valid), 0);
		check("cpu_done", 32'(cpu_done), 0);
		check("fetch_out.valid", 32'(fetch_out.valid), 0);
		measure_stretch("stretch after rst");
		@(posedge clk2);
		#1 reset_button = 1'b1;
		@(posedge clk2);
		#1 reset_button = 1'b0;
		measure_stretch("stretch after button");
		@(posedge clk2);
		#1;
		dl_req.active = 1'b1;
		dl_req.index = 5'd3;                            // rom image
		repeat (5) @(posedge clk2);
		#1 dl_req.active = 1'b0;
		measure_stretch("stretch after rom download");
		repeat (4) @(posedge clk2);
		end_test("reset stretch");

		// test 2 reads random rom and base ram words, then io and open space
		for (int i = 0; i < 12; i++) begin
			if (i % 2 == 0)
				a = 20'(rand_bits(16)) & 20'hffffe;
			else
				a = 20'h20000 | (20'(rand_bits(17)) & 20'h1fffe);
			cpu_access(a, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
		end
		x0 = xfers;
		cpu_access(20'h18010, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
		cpu_access(20'hc0000, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
		check("memory transfers", xfers, x0);
		end_test("processor reads");

		// test 3 runs extended ram with and without the option
		ram_640k = 1'b1;
		cpu_access(20'h45678, 1'b0, 1'b1, 1'b1, 1'b1, 16'hbeef);
		cpu_access(20'h45678, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
		ram_640k = 1'b0;
		cpu_access(20'h45678, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
		cpu_access(20'h45678, 1'b0, 1'b1, 1'b1, 1'b1, 16'h1234);
		check("ext ram word", 32'(mem_peek(word_addr_of(20'h45678))), 32'h0000beef);
		ram_640k = 1'b1;
		end_test("extended ram");

		// test 4 covers the byte lanes
		cpu_access(20'h23456, 1'b0, 1'b1, 1'b1, 1'b1, 16'h0000);
		cpu_access(20'h23456, 1'b0, 1'b1, 1'b1, 1'b0, 16'ha5c3);
		cpu_access(20'h23456, 1'b0, 1'b1, 1'b0, 1'b1, 16'h7e19);
		cpu_access(20'h23456, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
		end_test("byte lanes");

		// test 5 downloads with a processor read waiting behind it
		w0 = wr_count;
		fork
			download_words(4, 25'h1000000, 5'd7);
			begin
				repeat (3) @(posedge clk2);
				cpu_access(20'h2a000, 1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
			end
		join
		check("cpu done after download", 32'(cpu_end_t > dl_end_t), 1);
		check("download write count", wr_count - w0, 4);
		end_test("download");

		// test 6 runs display and microdrive fetches beside processor reads
		fork
			begin
				video_fetch(1'b1, 1'b0, 1'b0, 1'b0, 19'(rand_bits(19)), 25'h0, 25'h0);
				video_fetch(1'b0, 1'b1, 1'b0, 1'b0, 19'h0, 25'(rand_bits(25)), 25'h0);
				video_fetch(1'b0, 1'b0, 1'b1, 1'b1, 19'h0, 25'h0, 25'(rand_bits(25)));
				video_fetch(1'b1, 1'b1, 1'b0, 1'b0, 19'h12345, 25'h0abcde, 25'h0);
				video_fetch(1'b1, 1'b0, 1'b1, 1'b1, 19'h54321, 25'h0, 25'h1777777);
			end
			for (int i = 0; i < 6; i++)
				cpu_access(20'h30000 | (20'(rand_bits(16)) & 20'hfffe),
				           1'b1, 1'b0, 1'b1, 1'b1, 16'h0);
		join
		repeat (4) @(posedge clk2);
		end_test("video fetches");

		$display("tests %0d failed %0d checks %0d errors %0d",
		         tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verification
src/ql_bus_pkg.sv
src/cpu_reset_gen.sv
src/sys_port.sv
src/video_port.sv
src/slot_sequencer.sv
src/ql_bus_arbiter.sv
verification/tb_ql_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ql bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing -j 0 \
	--top-module tb_ql_bus \
	-f vlog.f \
	-o sim_ql_bus

./obj_dir/sim_ql_bus > sim.log 2>&1
cat sim.log

# fails the script when the pass line is missing
grep -q "^TEST PASS$" sim.log
echo "simulation passed"
